//--- design/ppu_pkg.sv
package ppu_pkg;

// ------------------------------------------------------------
// Bus geometry

// Byte address width shared by the RAM, the master and both requesters
localparam int W_ADDR = 12;
// The steering logic in the bus master assumes a 32-bit data bus
localparam int W_DATA = 32;
// Requester 0 is the line fetcher and wins over requester 1, the host reader
localparam int N_REQ = 2;

// ------------------------------------------------------------
// Picture and timing geometry

localparam int LINE_WORDS = 8;
localparam int N_LINES = 4;
localparam int LINE_CYCLES = 64;
// Extra cycles that the video RAM adds to every data phase
localparam int VRAM_WAIT = 1;

// ------------------------------------------------------------
// Types

typedef logic [W_ADDR-1:0] addr_t;
typedef logic [W_DATA-1:0] data_t;
// Same encoding as the low two bits of hsize: 0 byte, 1 halfword, 2 word
typedef logic [1:0] size_t;
typedef logic [$clog2(N_LINES)-1:0] line_t;

// Line fetcher FSM
// IDLE waits for a line start, REQ holds a bus request, PUSH offers one word
typedef enum logic [1:0] {
	IDLE,
	REQ,
	PUSH
} fetch_state_t;

endpackage

//--- design/ppu_busmaster.sv
`timescale 1ns/1ps

module ppu_busmaster (
	input  logic                                  clk,
	input  logic                                  rst_n,

	// A request stays valid, with address and size held, until rdy is seen
	input  logic [ppu_pkg::N_REQ-1:0]             req_vld,
	input  ppu_pkg::addr_t [ppu_pkg::N_REQ-1:0]   req_addr,
	input  ppu_pkg::size_t [ppu_pkg::N_REQ-1:0]   req_size,
	output logic [ppu_pkg::N_REQ-1:0]             req_rdy,
	output ppu_pkg::data_t                        req_data,

	// AHB-lite master port
	output ppu_pkg::addr_t                        haddr,
	output logic                                  hwrite,
	output logic [1:0]                            htrans,
	output logic [2:0]                            hsize,
	output logic [2:0]                            hburst,
	output logic [3:0]                            hprot,
	output logic                                  hmastlock,
	output ppu_pkg::data_t                        hwdata,
	input  logic                                  hready,
	input  logic                                  hresp,
	input  ppu_pkg::data_t                        hrdata
);

localparam logic [1:0] HTRANS_IDLE = 2'b00;
localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
localparam ppu_pkg::size_t SIZE_BYTE = 2'd0;
localparam ppu_pkg::size_t SIZE_HALF = 2'd1;

// Read-only master, single non-locked data accesses
assign hwrite = 1'b0;
assign hburst = 3'b000;
assign hprot = 4'b0011;
assign hmastlock = 1'b0;
assign hwdata = '0;

// ------------------------------------------------------------
// Arbitration

logic [ppu_pkg::N_REQ-1:0] eligible;
logic [ppu_pkg::N_REQ-1:0] grant_comb;
logic [ppu_pkg::N_REQ-1:0] grant_aph_reg;
logic [ppu_pkg::N_REQ-1:0] grant_aph;
logic [ppu_pkg::N_REQ-1:0] grant_dph;
logic                      use_buf;

// A requester whose data phase is still open keeps vld high until rdy,
// so it is kept out of the pick to avoid issuing its transfer twice
assign eligible = req_vld & ~grant_dph;
// Lowest set bit wins
assign grant_comb = eligible & ~(eligible - 1'b1);

// A stalled address phase keeps its grant from the register
assign use_buf = |grant_aph_reg;
assign grant_aph = use_buf ? grant_aph_reg : grant_comb;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		grant_aph_reg <= '0;
		grant_dph <= '0;
	end else if (hready) begin
		grant_aph_reg <= '0;
		grant_dph <= grant_aph;
	end else begin
		grant_aph_reg <= grant_aph;
	end
end

// ------------------------------------------------------------
// Address phase

ppu_pkg::addr_t mux_addr;
ppu_pkg::size_t mux_size;
ppu_pkg::addr_t aph_addr;
ppu_pkg::size_t aph_size;

// One-hot select of the granted requester's attributes
always_comb begin
	mux_addr = '0;
	mux_size = '0;
	for (int i = 0; i < ppu_pkg::N_REQ; i++) begin
		if (grant_comb[i]) begin
			mux_addr = mux_addr | req_addr[i];
			mux_size = mux_size | req_size[i];
		end
	end
end

// Attributes are captured in the first stalled cycle and replayed after
always_ff @(posedge clk) begin
	if (|grant_comb && !use_buf && !hready) begin
		aph_addr <= mux_addr;
		aph_size <= mux_size;
	end
end

assign haddr = use_buf ? aph_addr : mux_addr;
assign hsize = {1'b0, use_buf ? aph_size : mux_size};
assign htrans = |grant_aph ? HTRANS_NONSEQ : HTRANS_IDLE;

// ------------------------------------------------------------
// Data phase steering

logic [1:0]     dph_lane;
ppu_pkg::size_t dph_size;
logic [7:0]     lane_byte;
logic [15:0]    lane_half;

always_ff @(posedge clk) begin
	if (hready) begin
		dph_lane <= haddr[1:0];
		dph_size <= hsize[1:0];
	end
end

// Bits above the transfer size are left as they come off the bus
always_comb begin
	lane_byte = hrdata[8 * dph_lane +: 8];
	lane_half = dph_lane[1] ? hrdata[31:16] : hrdata[15:0];
	case (dph_size)
	SIZE_BYTE: req_data = {hrdata[31:8], lane_byte};
	SIZE_HALF: req_data = {hrdata[31:16], lane_half};
	default:   req_data = hrdata;
	endcase
end

assign req_rdy = grant_dph & {ppu_pkg::N_REQ{hready}};

// A waiting address phase must not move, whoever asked for it
a_aph_hold: assert property (@(posedge clk) disable iff (!rst_n)
	htrans[1] && !hready |=> htrans[1] && $stable(haddr) && $stable(hsize));

// Neither requester has a way to handle an error, so the slave never sends one
a_no_error: assert property (@(posedge clk) disable iff (!rst_n) !hresp);

endmodule

//--- design/ppu_vram.sv
`timescale 1ns/1ps

module ppu_vram (
	input  logic           clk,
	input  logic           rst_n,

	// AHB-lite read slave
	input  ppu_pkg::addr_t haddr,
	input  logic [1:0]     htrans,
	input  logic [2:0]     hsize,
	output logic           hready,
	output ppu_pkg::data_t hrdata,

	// Host write port, always accepts
	input  logic           wr_en,
	input  ppu_pkg::addr_t wr_addr,
	input  ppu_pkg::data_t wr_data
);

localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
localparam logic [2:0] HSIZE_WORD = 3'b010;
localparam int DEPTH = (1 << ppu_pkg::W_ADDR) / 4;

typedef logic [$clog2(ppu_pkg::VRAM_WAIT + 1)-1:0] wait_t;
typedef logic [ppu_pkg::W_ADDR-3:0] word_t;

ppu_pkg::data_t mem [DEPTH];
wait_t          wait_cnt;
word_t          dph_word;
logic           accept;

// Byte lanes are sorted out by the master, the RAM always returns a word
assign accept = hready && htrans == HTRANS_NONSEQ;

// The bus is stalled for as long as the countdown is running
assign hready = wait_cnt == '0;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		wait_cnt <= '0;
	end else if (accept) begin
		wait_cnt <= wait_t'(ppu_pkg::VRAM_WAIT);
	end else if (!hready) begin
		wait_cnt <= wait_cnt - 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (accept)
		dph_word <= haddr[ppu_pkg::W_ADDR-1:2];
	if (wr_en)
		mem[wr_addr[ppu_pkg::W_ADDR-1:2]] <= wr_data;
end

// Read in the last cycle of the data phase, so a write during the
// wait cycles is already visible
assign hrdata = mem[dph_word];

// Only a word or narrower is ever asked for
a_size_ok: assert property (@(posedge clk) disable iff (!rst_n)
	htrans == HTRANS_NONSEQ |-> hsize <= HSIZE_WORD);

// A transfer offered while a data phase is still counting is not taken,
// so it has to wait unchanged until the countdown ends
a_wait_phase: assert property (@(posedge clk) disable iff (!rst_n)
	htrans == HTRANS_NONSEQ && !hready |=> htrans == HTRANS_NONSEQ
		&& $stable(haddr) && $stable(hsize));

endmodule

//--- design/ppu_beam_counter.sv
`timescale 1ns/1ps

module ppu_beam_counter (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           run,
	output logic           line_start,
	output ppu_pkg::line_t line_y
);

typedef logic [$clog2(ppu_pkg::LINE_CYCLES)-1:0] cyc_t;

cyc_t cyc;

// Counting freezes while run is low, the beam simply holds its position
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		cyc <= '0;
		line_y <= '0;
		line_start <= 1'b0;
	end else if (run) begin
		// Pulse registered from cycle 0, so line_y has already stepped
		line_start <= cyc == '0;
		if (cyc == cyc_t'(ppu_pkg::LINE_CYCLES - 1)) begin
			cyc <= '0;
			// Wrap of the frame back to the top line
			if (line_y == ppu_pkg::line_t'(ppu_pkg::N_LINES - 1))
				line_y <= '0;
			else
				line_y <= line_y + 1'b1;
		end else begin
			cyc <= cyc + 1'b1;
		end
	end else begin
		line_start <= 1'b0;
	end
end

endmodule

//--- design/ppu_line_fetcher.sv
`timescale 1ns/1ps

module ppu_line_fetcher (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           line_start,
	input  ppu_pkg::line_t line_y,

	// Bus requester side
	output logic           req_vld,
	output ppu_pkg::addr_t req_addr,
	output ppu_pkg::size_t req_size,
	input  logic           req_rdy,
	input  ppu_pkg::data_t req_data,

	// Pixel word stream
	output logic           pix_valid,
	input  logic           pix_ready,
	output ppu_pkg::data_t pix_data,
	output ppu_pkg::line_t pix_line,
	output logic           pix_last,
	output logic           overrun
);

typedef logic [$clog2(ppu_pkg::LINE_WORDS)-1:0] word_idx_t;

ppu_pkg::fetch_state_t state;
word_idx_t             word_cnt;
ppu_pkg::addr_t        base_addr;
logic                  final_word;

// Lines sit back to back in RAM, LINE_WORDS words each
assign base_addr = ppu_pkg::addr_t'(line_y * ppu_pkg::LINE_WORDS * 4);
assign final_word = word_cnt == word_idx_t'(ppu_pkg::LINE_WORDS - 1);

// Pixel fetches are always whole words
assign req_size = ppu_pkg::size_t'(2);
assign req_vld = state == ppu_pkg::REQ;
assign pix_valid = state == ppu_pkg::PUSH;

// ------------------------------------------------------------
// FSM

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state <= ppu_pkg::IDLE;
		word_cnt <= '0;
		pix_last <= 1'b0;
		overrun <= 1'b0;
	end else begin
		// A line start while busy drops that line for good
		if (line_start && state != ppu_pkg::IDLE)
			overrun <= 1'b1;
		case (state)
		ppu_pkg::IDLE: begin
			if (line_start) begin
				word_cnt <= '0;
				state <= ppu_pkg::REQ;
			end
		end
		ppu_pkg::REQ: begin
			if (req_rdy) begin
				pix_last <= final_word;
				state <= ppu_pkg::PUSH;
			end
		end
		ppu_pkg::PUSH: begin
			// No new request until the word has left
			if (pix_ready) begin
				word_cnt <= word_cnt + 1'b1;
				state <= pix_last ? ppu_pkg::IDLE : ppu_pkg::REQ;
			end
		end
		default: state <= ppu_pkg::IDLE;
		endcase
	end
end

// Address, line tag and word are only sampled in the states that use them
always_ff @(posedge clk) begin
	if (state == ppu_pkg::IDLE && line_start) begin
		req_addr <= base_addr;
		pix_line <= line_y;
	end
	if (state == ppu_pkg::PUSH && pix_ready)
		req_addr <= req_addr + 3'd4;
	if (state == ppu_pkg::REQ && req_rdy)
		pix_data <= req_data;
end

// The master may only answer a request that is actually raised,
// otherwise a word would be taken in the wrong state
a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
	req_rdy |-> req_vld);

endmodule

//--- design/ppu_host_reader.sv
`timescale 1ns/1ps

module ppu_host_reader (
	input  logic           clk,
	input  logic           rst_n,

	// Host request and response streams
	input  logic           rd_req_valid,
	output logic           rd_req_ready,
	input  ppu_pkg::addr_t rd_addr,
	input  ppu_pkg::size_t rd_size,
	output logic           rd_resp_valid,
	input  logic           rd_resp_ready,
	output ppu_pkg::data_t rd_resp_data,

	// Bus requester side
	output logic           req_vld,
	output ppu_pkg::addr_t req_addr,
	output ppu_pkg::size_t req_size,
	input  logic           req_rdy,
	input  ppu_pkg::data_t req_data
);

ppu_pkg::data_t masked;

// One read at a time, from request through response
assign rd_req_ready = !req_vld && !rd_resp_valid;

// Zero everything above the requested size
always_comb begin
	case (req_size)
	2'd0:    masked = ppu_pkg::data_t'(req_data[7:0]);
	2'd1:    masked = ppu_pkg::data_t'(req_data[15:0]);
	default: masked = req_data;
	endcase
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		req_vld <= 1'b0;
		rd_resp_valid <= 1'b0;
	end else begin
		if (rd_req_valid && rd_req_ready)
			req_vld <= 1'b1;
		else if (req_rdy)
			req_vld <= 1'b0;
		if (req_vld && req_rdy)
			rd_resp_valid <= 1'b1;
		else if (rd_resp_ready)
			rd_resp_valid <= 1'b0;
	end
end

always_ff @(posedge clk) begin
	if (rd_req_valid && rd_req_ready) begin
		req_addr <= rd_addr;
		req_size <= rd_size;
	end
	if (req_vld && req_rdy)
		rd_resp_data <= masked;
end

endmodule

//--- design/ppu_fetch_top.sv
`timescale 1ns/1ps

module ppu_fetch_top (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           run,

	// Picture load port into the video RAM
	input  logic           wr_en,
	input  ppu_pkg::addr_t wr_addr,
	input  ppu_pkg::data_t wr_data,

	// Pixel word stream
	output logic           pix_valid,
	input  logic           pix_ready,
	output ppu_pkg::data_t pix_data,
	output ppu_pkg::line_t pix_line,
	output logic           pix_last,
	output logic           overrun,

	// Host reads
	input  logic           rd_req_valid,
	output logic           rd_req_ready,
	input  ppu_pkg::addr_t rd_addr,
	input  ppu_pkg::size_t rd_size,
	output logic           rd_resp_valid,
	input  logic           rd_resp_ready,
	output ppu_pkg::data_t rd_resp_data
);

logic                                line_start;
ppu_pkg::line_t                      line_y;

// Requester vectors, index 0 is the fetcher and 1 the host reader
logic [ppu_pkg::N_REQ-1:0]           req_vld;
logic [ppu_pkg::N_REQ-1:0]           req_rdy;
ppu_pkg::addr_t [ppu_pkg::N_REQ-1:0] req_addr;
ppu_pkg::size_t [ppu_pkg::N_REQ-1:0] req_size;
ppu_pkg::data_t                      req_data;

// AHB-lite between master and RAM
ppu_pkg::addr_t                      haddr;
logic [1:0]                          htrans;
logic [2:0]                          hsize;
logic                                hready;
ppu_pkg::data_t                      hrdata;

ppu_beam_counter beam_u (
	.clk        (clk),
	.rst_n      (rst_n),
	.run        (run),
	.line_start (line_start),
	.line_y     (line_y)
);

ppu_line_fetcher fetch_u (
	.clk        (clk),
	.rst_n      (rst_n),
	.line_start (line_start),
	.line_y     (line_y),
	.req_vld    (req_vld[0]),
	.req_addr   (req_addr[0]),
	.req_size   (req_size[0]),
	.req_rdy    (req_rdy[0]),
	.req_data   (req_data),
	.pix_valid  (pix_valid),
	.pix_ready  (pix_ready),
	.pix_data   (pix_data),
	.pix_line   (pix_line),
	.pix_last   (pix_last),
	.overrun    (overrun)
);

ppu_host_reader host_u (
	.clk           (clk),
	.rst_n         (rst_n),
	.rd_req_valid  (rd_req_valid),
	.rd_req_ready  (rd_req_ready),
	.rd_addr       (rd_addr),
	.rd_size       (rd_size),
	.rd_resp_valid (rd_resp_valid),
	.rd_resp_ready (rd_resp_ready),
	.rd_resp_data  (rd_resp_data),
	.req_vld       (req_vld[1]),
	.req_addr      (req_addr[1]),
	.req_size      (req_size[1]),
	.req_rdy       (req_rdy[1]),
	.req_data      (req_data)
);

// The RAM has no use for the master's write and protection outputs,
// and it never answers with an error
ppu_busmaster master_u (
	.clk       (clk),
	.rst_n     (rst_n),
	.req_vld   (req_vld),
	.req_addr  (req_addr),
	.req_size  (req_size),
	.req_rdy   (req_rdy),
	.req_data  (req_data),
	.haddr     (haddr),
	.hwrite    (),
	.htrans    (htrans),
	.hsize     (hsize),
	.hburst    (),
	.hprot     (),
	.hmastlock (),
	.hwdata    (),
	.hready    (hready),
	.hresp     (1'b0),
	.hrdata    (hrdata)
);

ppu_vram vram_u (
	.clk     (clk),
	.rst_n   (rst_n),
	.haddr   (haddr),
	.htrans  (htrans),
	.hsize   (hsize),
	.hready  (hready),
	.hrdata  (hrdata),
	.wr_en   (wr_en),
	.wr_addr (wr_addr),
	.wr_data (wr_data)
);

endmodule

//--- bench/tb_ppu_fetch.sv
`timescale 1ns/1ps

module tb_ppu_fetch;

localparam int RESET_CYCLES = 8;
// Only the low part of the RAM is loaded and read back
localparam int FILL_WORDS = 64;
localparam int LANE_REPS = 4;
// Every rep reads four bytes, two halfwords and one word
localparam int SOLO_READS = LANE_REPS * 7;
localparam int HOST_READ_CYCLES = 16;
localparam int WATCHDOG_CYCLES = RESET_CYCLES + FILL_WORDS
	+ ppu_pkg::N_LINES * ppu_pkg::LINE_CYCLES * 3 + SOLO_READS * HOST_READ_CYCLES;

typedef logic [$clog2(FILL_WORDS)-1:0] shadow_idx_t;

logic           clk;
logic           rst_n;
logic           run;
logic           wr_en;
ppu_pkg::addr_t wr_addr;
ppu_pkg::data_t wr_data;
logic           pix_valid;
logic           pix_ready;
ppu_pkg::data_t pix_data;
ppu_pkg::line_t pix_line;
logic           pix_last;
logic           overrun;
logic           rd_req_valid;
logic           rd_req_ready;
ppu_pkg::addr_t rd_addr;
ppu_pkg::size_t rd_size;
logic           rd_resp_valid;
logic           rd_resp_ready;
ppu_pkg::data_t rd_resp_data;

// Copy of everything written into the RAM
ppu_pkg::data_t shadow [FILL_WORDS];

// Stimulus controls for the ready driver
logic pix_hold;
int   pix_pct;
logic ovr_allowed;

// Scoreboard state
int             word_idx;
int             lines_done;
int             host_done;
ppu_pkg::line_t exp_line;
logic           ovr_prev;
ppu_pkg::data_t host_exp;
ppu_pkg::data_t pix_exp;

int pix_errors;
int host_errors;
int other_errors;

ppu_fetch_top DUT (
	.clk           (clk),
	.rst_n         (rst_n),
	.run           (run),
	.wr_en         (wr_en),
	.wr_addr       (wr_addr),
	.wr_data       (wr_data),
	.pix_valid     (pix_valid),
	.pix_ready     (pix_ready),
	.pix_data      (pix_data),
	.pix_line      (pix_line),
	.pix_last      (pix_last),
	.overrun       (overrun),
	.rd_req_valid  (rd_req_valid),
	.rd_req_ready  (rd_req_ready),
	.rd_addr       (rd_addr),
	.rd_size       (rd_size),
	.rd_resp_valid (rd_resp_valid),
	.rd_resp_ready (rd_resp_ready),
	.rd_resp_data  (rd_resp_data)
);

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

// ------------------------------------------------------------
// Reference model

// Byte lane shifted down to bit 0, halfword by addr[1], upper bits zero
function automatic ppu_pkg::data_t expect_read(input ppu_pkg::addr_t addr,
		input ppu_pkg::size_t size);
	ppu_pkg::data_t word;
	word = shadow[shadow_idx_t'(addr >> 2)];
	case (size)
	2'd0:    expect_read = (word >> {addr[1:0], 3'b000}) & 32'h0000_00ff;
	2'd1:    expect_read = (word >> {addr[1], 4'b0000}) & 32'h0000_ffff;
	default: expect_read = word;
	endcase
endfunction

// Lines are stored back to back, LINE_WORDS words each
assign pix_exp = shadow[shadow_idx_t'(int'(exp_line) * ppu_pkg::LINE_WORDS + word_idx)];

always @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		word_idx <= 0;
		lines_done <= 0;
		host_done <= 0;
		exp_line <= '0;
		ovr_prev <= 1'b0;
		host_exp <= '0;
	end else begin
		if (rd_req_valid && rd_req_ready)
			host_exp <= expect_read(rd_addr, rd_size);
		if (rd_resp_valid && rd_resp_ready)
			host_done <= host_done + 1;
		if (pix_valid && pix_ready) begin
			if (word_idx == ppu_pkg::LINE_WORDS - 1) begin
				word_idx <= 0;
				lines_done <= lines_done + 1;
				// A line start dropped during this line moves the next index on by two
				exp_line <= ppu_pkg::line_t'((int'(exp_line) + 1 + int'(overrun && !ovr_prev))
					% ppu_pkg::N_LINES);
				ovr_prev <= overrun;
			end else begin
				word_idx <= word_idx + 1;
			end
		end
	end
end

// ------------------------------------------------------------
// Checks

a_pix_word: assert property (@(posedge clk) disable iff (!rst_n)
	pix_valid && pix_ready |-> pix_data == pix_exp)
	else begin
		pix_errors++;
		$display("Mismatch pixel_word: expected %08h, actual %08h",
			$sampled(pix_exp), $sampled(pix_data));
	end

a_pix_line: assert property (@(posedge clk) disable iff (!rst_n)
	pix_valid && pix_ready |-> pix_line == exp_line)
	else begin
		pix_errors++;
		$display("Mismatch pixel_line: expected %0d, actual %0d",
			$sampled(exp_line), $sampled(pix_line));
	end

a_pix_last: assert property (@(posedge clk) disable iff (!rst_n)
	pix_valid && pix_ready |-> pix_last == (word_idx == ppu_pkg::LINE_WORDS - 1))
	else begin
		pix_errors++;
		$display("Mismatch pixel_last: expected %0b, actual %0b",
			$sampled(word_idx) == ppu_pkg::LINE_WORDS - 1, $sampled(pix_last));
	end

a_pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
	pix_valid && !pix_ready |=> pix_valid && $stable(pix_data) && $stable(pix_line)
		&& $stable(pix_last))
	else begin
		pix_errors++;
		$display("Pixel stream changed while waiting for ready");
	end

a_host_data: assert property (@(posedge clk) disable iff (!rst_n)
	rd_resp_valid && rd_resp_ready |-> rd_resp_data == host_exp)
	else begin
		host_errors++;
		$display("Mismatch host_read: expected %08h, actual %08h",
			$sampled(host_exp), $sampled(rd_resp_data));
	end

a_host_hold: assert property (@(posedge clk) disable iff (!rst_n)
	rd_resp_valid && !rd_resp_ready |=> rd_resp_valid && $stable(rd_resp_data))
	else begin
		host_errors++;
		$display("Host response changed while waiting for ready");
	end

a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
	!ovr_allowed |-> !overrun)
	else begin
		other_errors++;
		$display("Overrun flag set although the pixel stream kept up");
	end

// ------------------------------------------------------------
// Stimulus

// Controls are sampled on the edge, so a change made mid-cycle acts one cycle later
initial begin
	logic hold_now;
	int   pct_now;
	pix_ready = 1'b0;
	rd_resp_ready = 1'b0;
	forever begin
		@(posedge clk);
		hold_now = pix_hold;
		pct_now = pix_pct;
		#1;
		pix_ready = !hold_now && ($urandom % 100) < pct_now;
		rd_resp_ready = ($urandom % 2) == 0;
	end
end

task automatic fill_ram();
	for (int i = 0; i < FILL_WORDS; i++) begin
		shadow[i] = $urandom;
		wr_en = 1'b1;
		wr_addr = ppu_pkg::addr_t'(i * 4);
		wr_data = shadow[i];
		@(posedge clk);
		#1;
	end
	wr_en = 1'b0;
endtask

// Called and returning 1 ns after a rising edge
task automatic host_read(input int word_sel, input int lane, input ppu_pkg::size_t size);
	int target;
	target = host_done + 1;
	rd_req_valid = 1'b1;
	rd_addr = ppu_pkg::addr_t'(word_sel * 4 + lane);
	rd_size = size;
	while (!rd_req_ready) begin
		@(posedge clk);
		#1;
	end
	@(posedge clk);
	#1;
	rd_req_valid = 1'b0;
	while (host_done != target) begin
		@(posedge clk);
		#1;
	end
endtask

task automatic host_read_random();
	ppu_pkg::size_t size;
	int             lane;
	size = ppu_pkg::size_t'($urandom % 3);
	lane = 0;
	if (size == 2'd0)
		lane = int'($urandom % 4);
	else if (size == 2'd1)
		lane = int'($urandom % 2) * 2;
	host_read(int'($urandom % FILL_WORDS), lane, size);
endtask

task automatic check_reset_outputs();
	if ({pix_valid, rd_resp_valid, rd_req_ready} != 3'b001) begin
		other_errors++;
		$display("Mismatch reset_outputs: expected 001, actual %b",
			{pix_valid, rd_resp_valid, rd_req_ready});
	end
endtask

initial begin
	int lines_goal;
	void'($urandom(32'he873));
	rst_n = 1'b0;
	run = 1'b0;
	wr_en = 1'b0;
	wr_addr = '0;
	wr_data = '0;
	rd_req_valid = 1'b0;
	rd_addr = '0;
	rd_size = '0;
	pix_hold = 1'b0;
	pix_pct = 100;
	ovr_allowed = 1'b0;
	pix_errors = 0;
	host_errors = 0;
	other_errors = 0;
	repeat (RESET_CYCLES) @(posedge clk);
	#1;
	rst_n = 1'b1;
	check_reset_outputs();
	fill_ram();

	// Every lane of every size, with the beam stopped and the bus quiet
	for (int rep = 0; rep < LANE_REPS; rep++) begin
		for (int lane = 0; lane < 4; lane++)
			host_read(int'($urandom % FILL_WORDS), lane, 2'd0);
		host_read(int'($urandom % FILL_WORDS), 0, 2'd1);
		host_read(int'($urandom % FILL_WORDS), 2, 2'd1);
		host_read(int'($urandom % FILL_WORDS), 0, 2'd2);
	end

	// One frame of lines with host reads competing for the bus
	run = 1'b1;
	pix_pct = 85;
	while (lines_done < ppu_pkg::N_LINES)
		host_read_random();

	// Stall the pixel stream until a line start is dropped
	ovr_allowed = 1'b1;
	pix_hold = 1'b1;
	while (!overrun) begin
		@(posedge clk);
		#1;
	end
	repeat (4) @(posedge clk);
	#1;
	pix_hold = 1'b0;
	lines_goal = lines_done + 2;
	while (lines_done < lines_goal) begin
		@(posedge clk);
		#1;
	end
	if (!overrun) begin
		other_errors++;
		$display("Overrun flag cleared before reset");
	end
	repeat (4) @(posedge clk);

	$display("Errors: pixel %0d, host %0d, other %0d", pix_errors, host_errors, other_errors);
	if (pix_errors + host_errors + other_errors == 0) begin
		$display("TESTBENCH PASSED");
	end else begin
		$display("TESTBENCH FAILED");
	end
	$finish;
end

initial begin
	repeat (WATCHDOG_CYCLES) @(posedge clk);
	$display("Timeout after %0d cycles, the test sequence did not finish", WATCHDOG_CYCLES);
	$display("TESTBENCH FAILED");
	$finish;
end

endmodule

//--- flist.f
design/ppu_pkg.sv
design/ppu_busmaster.sv
design/ppu_vram.sv
design/ppu_beam_counter.sv
design/ppu_line_fetcher.sv
design/ppu_host_reader.sv
design/ppu_fetch_top.sv
bench/tb_ppu_fetch.sv

//--- Makefile
SIM     = verilator
TOP     = tb_ppu_fetch
FLIST   = flist.f
VFLAGS  = --binary --timing --assert -Wno-fatal
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SOURCES = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
